//--- vlog.f
source/dsp_pkg.sv
source/dau_ctrl_if.sv
source/apb_dau_port.sv
source/dau_alu.sv
source/dau_datapath.sv
source/dau_cond.sv
source/dsp_dau_top.sv
sim/dau_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the DAU testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module dau_tb -f vlog.f &&
./obj_dir/Vdau_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- sim/dau_tb.sv
// ======================================================================
// self-checking testbench of the DSP data arithmetic unit
// APB read and write driver with per-access timeout
// shadow model of registers, product pipeline, flags and counters
// immediate assertions on prdata, pslverr and pready
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module dau_tb;
    import dsp_pkg::*;

    logic        clk = 1'b0;
    logic        rst;
    logic        psel, penable, pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready, pslverr;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng_state = 32'h7682ddb6;

    // shadow model
    logic [15:0] m_x, m_yh, m_yl;
    logic [31:0] m_p;
    logic [35:0] m_a [2];
    logic [6:0]  m_auc;
    logic [3:0]  m_flags;           // lmi, leq, llv, lmv
    logic        m_ov0, m_ov1;
    logic [7:0]  m_c [3];
    logic        m_con;

    dsp_dau_top uut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #50 clk = ~clk;  // 100 ns period

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // expected read data of an address in the shadow model
    function automatic logic [31:0] exp_read(input logic [7:0] addr);
        logic [15:0] w;
        w = 16'h0000;
        case (addr)
            8'h00:    w = m_x;
            8'h04:    w = m_yh;
            8'h08:    w = m_yl;
            8'h0C:    w = {9'b0, m_auc};
            8'h10:    w = {m_flags, 2'b00, m_ov1, m_ov0, m_a[1][35:32], m_a[0][35:32]};
            8'h14:    w = {{8{m_c[0][7]}}, m_c[0]};
            8'h18:    w = {{8{m_c[1][7]}}, m_c[1]};
            8'h1C:    w = {{8{m_c[2][7]}}, m_c[2]};
            ADDR_A0H: w = m_a[0][31:16];
            ADDR_A0L: w = m_a[0][15:0];
            ADDR_A1H: w = m_a[1][31:16];
            ADDR_A1L: w = m_a[1][15:0];
            default:  w = 16'h0000;
        endcase
        if (addr == ADDR_COND) return {31'b0, m_con};
        return {16'h0000, w};
    endfunction

    // one APB transfer through setup and access phase
    task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waits;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        assert (pready) else begin
            errors++;
            $display("pready low in the first access cycle at addr %h", addr);
        end
        waits = 0;
        while (!pready && waits < 16) begin
            @(negedge clk);
            waits++;
        end
        if (!pready) begin
            $display("timeout waiting for pready at addr %h", addr);
            $display("%0d errors in %0d checks", errors + 1, checks);
            $display("CHECKS FAILED");
            $finish;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_slverr(input logic [7:0] addr, input logic got, input logic exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("MISMATCH pslverr at addr %h: got %h, expected %h", addr, got, exp);
        end
    endtask

    task automatic check_read(input logic [7:0] addr);
        logic [31:0] rd;
        logic [31:0] exp;
        logic        err;
        bus_access(1'b0, addr, 32'h0, rd, err);
        exp = exp_read(addr);
        check_slverr(addr, err, 1'b0);
        checks++;
        assert (rd == exp) else begin
            errors++;
            $display("MISMATCH prdata at addr %h: got %h, expected %h", addr, rd, exp);
        end
    endtask

    task automatic check_all();
        for (int i = 0; i < 8; i++) check_read(8'(i * 4));
        check_read(ADDR_COND);
        check_read(ADDR_A0H);
        check_read(ADDR_A0L);
        check_read(ADDR_A1H);
        check_read(ADDR_A1L);
    endtask

    task automatic load_reg(input logic [2:0] code, input logic [15:0] data);
        logic [31:0] rd;
        logic        err;
        bus_access(1'b1, {3'b000, code, 2'b00}, {xorshift() & 32'hFFFF0000} | data, rd, err);
        check_slverr({3'b000, code, 2'b00}, err, 1'b0);
        case (code)
            3'd0: m_x = data;
            3'd1: begin
                m_yh = data;
                if (!m_auc[6]) m_yl = 16'h0000;
            end
            3'd2: m_yl = data;
            3'd3: m_auc = data[6:0];
            3'd5: m_c[0] = data[7:0];
            3'd6: m_c[1] = data[7:0];
            3'd7: m_c[2] = data[7:0];
            default: ;
        endcase
    endtask

    task automatic run_op(input logic [5:0] op);
        logic [31:0]        rd;
        logic               err, d, s, defined;
        logic [3:0]         f;
        logic signed [36:0] src, pe, ye, res;
        logic signed [31:0] prod;
        bus_access(1'b1, ADDR_OP, {26'b0, op}, rd, err);
        check_slverr(ADDR_OP, err, 1'b0);
        {d, s, f} = op;
        src = {m_a[s][35], m_a[s]};
        pe  = {{5{m_p[31]}}, m_p};           // old product
        if (m_auc[1:0] == 2'd2) pe = pe <<< 2;
        else if (m_auc[0]) pe = pe >>> 2;
        ye = {{5{m_yh[15]}}, m_yh, m_yl};
        defined = 1'b1;
        case (f)
            F1_P:    res = pe;
            F1_ADDP: res = src + pe;
            F1_SUBP: res = src - pe;
            F1_OR:   res = src | ye;
            F1_XOR:  res = src ^ ye;
            F1_TST:  res = src & ye;
            F1_Y:    res = ye;
            F1_ADDY: res = src + ye;
            F1_SUBY: res = src - ye;
            default: begin
                res     = src;               // mpy and reserved leave flags alone
                defined = 1'b0;
            end
        endcase
        if (defined) begin
            m_flags = {res[35], res[35:0] == 36'd0, res[36] != res[35],
                       res[35:31] != 5'b00000 && res[35:31] != 5'b11111};
            m_ov1 = d & (res[36] != res[35]);
            m_ov0 = !d & (res[36] != res[35]);
            if (f != F1_TST) m_a[d] = res[35:0];
        end
        if (f < 4'd4) begin
            prod = $signed({{16{m_x[15]}}, m_x}) * $signed({{16{m_yh[15]}}, m_yh});
            m_p  = prod;
        end
    endtask

    task automatic eval_cond(input logic [4:0] c);
        logic [31:0] rd;
        logic        err, lmi, leq, llv, lmv, r;
        bus_access(1'b1, ADDR_COND, {27'b0, c}, rd, err);
        check_slverr(ADDR_COND, err, 1'b0);
        {lmi, leq, llv, lmv} = m_flags;
        case (c)
            5'd0:    r = lmi;
            5'd1:    r = !lmi;
            5'd2:    r = leq;
            5'd3:    r = !leq;
            5'd4:    r = llv;
            5'd5:    r = !llv;
            5'd6:    r = lmv;
            5'd7:    r = !lmv;
            5'd10:   r = !m_c[0][7];
            5'd11:   r = m_c[0][7];
            5'd12:   r = !m_c[1][7];
            5'd13:   r = m_c[1][7];
            5'd15:   r = 1'b0;
            5'd16:   r = !lmi && !leq;
            5'd17:   r = lmi || leq;
            default: r = 1'b1;
        endcase
        m_con = r;
        if (c == 5'd10 || c == 5'd11) m_c[0] = m_c[0] + 8'd1;
        if (c == 5'd12 || c == 5'd13) m_c[1] = m_c[1] + 8'd1;
        check_read(ADDR_COND);
    endtask

    task automatic expect_error(input logic wr, input logic [7:0] addr);
        logic [31:0] rd;
        logic        err;
        bus_access(wr, addr, xorshift(), rd, err);
        check_slverr(addr, err, 1'b1);
    endtask

    initial begin
        logic [31:0] rnd;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h00;
        pwdata  = 32'h0;
        {m_x, m_yh, m_yl, m_p, m_auc, m_flags, m_ov0, m_ov1, m_con} = '0;
        m_a[0] = '0;
        m_a[1] = '0;
        for (int i = 0; i < 3; i++) m_c[i] = 8'h00;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // reset values and then loads
        check_all();
        load_reg(R_YL, 16'h1234);
        load_reg(R_YH, 16'h5678);
        check_read(8'h08);
        load_reg(R_AUC, 16'h0040);
        load_reg(R_YL, 16'h9ABC);
        load_reg(R_YH, 16'hDEF0);
        check_read(8'h08);
        repeat (24) begin
            rnd = xorshift();
            if (rnd[18:16] == R_PSW) rnd[18:16] = R_C0;
            load_reg(rnd[18:16], rnd[15:0]);
            check_read({3'b000, rnd[18:16], 2'b00});
        end

        // product pipeline for each scale
        for (int sc = 0; sc < 4; sc++) begin
            load_reg(R_AUC, 16'(sc));
            load_reg(R_X, 16'(xorshift()));
            load_reg(R_YH, 16'(xorshift()));
            run_op({2'b00, F1_MPY});
            run_op({1'(sc), 1'b0, F1_P});
            check_all();
        end

        // random operation mix including reserved codes
        repeat (80) begin
            rnd = xorshift();
            if (rnd[31:30] == 2'b00) load_reg({1'b0, rnd[29:28]}, rnd[27:12]);
            run_op(rnd[5:0]);
            check_all();
        end

        // drive both accumulators past 36 bits
        load_reg(R_AUC, 16'h0040);
        load_reg(R_YH, 16'h7FFF);
        load_reg(R_YL, 16'hFFFF);
        run_op({2'b00, F1_Y});
        repeat (20) begin
            run_op({2'b00, F1_ADDY});
            for (int c = 0; c < 8; c++) eval_cond(5'(c));  // llv and lmv set here
            check_all();
        end
        load_reg(R_YH, 16'h8000);
        load_reg(R_YL, 16'h0000);
        run_op({2'b11, F1_Y});
        repeat (20) begin
            run_op({2'b11, F1_ADDY});
            check_all();
        end

        // every condition code under several flag states
        for (int r = 0; r < 6; r++) begin
            rnd = (r == 0) ? 32'h0 : xorshift();
            load_reg(R_YH, rnd[31:16]);
            load_reg(R_YL, rnd[15:0]);
            load_reg(R_C0, 16'(xorshift()));
            load_reg(R_C1, 16'(xorshift()));
            run_op({r[0], 1'b0, F1_Y});
            for (int c = 0; c < 32; c++) eval_cond(5'(c));
            check_all();
        end
        load_reg(R_C0, 16'h007E);
        repeat (4) begin
            eval_cond(COND_C0GE);
            check_read(8'h14);
        end
        load_reg(R_C1, 16'h007E);
        repeat (4) begin
            eval_cond(COND_C1LT);
            check_read(8'h18);
        end

        // illegal accesses leave the registers alone
        expect_error(1'b1, 8'h38);
        expect_error(1'b0, 8'h38);
        expect_error(1'b1, 8'h40);
        expect_error(1'b0, 8'hFF);
        expect_error(1'b0, 8'h22);
        expect_error(1'b1, 8'h01);
        expect_error(1'b1, 8'h10);
        expect_error(1'b1, ADDR_A0H);
        expect_error(1'b1, ADDR_A0L);
        expect_error(1'b1, ADDR_A1H);
        expect_error(1'b1, ADDR_A1L);
        expect_error(1'b0, ADDR_OP);
        check_all();

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/dsp_dau_top.sv
// ======================================================================
// top level of the DSP data arithmetic unit behind an APB slave
// APB port, datapath with ALU, counters and condition unit
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module dsp_dau_top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         psel,
    input  wire                         penable,
    input  wire                         pwrite,
    input  wire [dsp_pkg::APB_AW-1:0]   paddr,
    input  wire [dsp_pkg::APB_DW-1:0]   pwdata,
    output logic [dsp_pkg::APB_DW-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr
);
    import dsp_pkg::*;

    word_t  reg_rdata;
    logic   con_result;
    flags_t flags;
    cnt_t   c0, c1, c2;

    dau_ctrl_if ctrl ();

    apb_dau_port u_port (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .ctrl       (ctrl.host),
        .reg_rdata  (reg_rdata),
        .con_result (con_result)
    );

    dau_datapath u_dp (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl.dp),
        .c0        (c0),
        .c1        (c1),
        .c2        (c2),
        .flags     (flags),
        .reg_rdata (reg_rdata)
    );

    dau_cond u_cond (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl.cu),
        .flags      (flags),
        .c0         (c0),
        .c1         (c1),
        .c2         (c2),
        .con_result (con_result)
    );

endmodule

`default_nettype wire

//--- source/dau_cond.sv
// ======================================================================
// counters c0, c1, c2 and the condition evaluator
// condition result latched on each evaluation
// c0 and c1 step when a condition tests them
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module dau_cond (
    input  wire                  clk,
    input  wire                  rst,
    dau_ctrl_if.cu               ctrl,
    input  wire dsp_pkg::flags_t flags,
    output dsp_pkg::cnt_t        c0,
    output dsp_pkg::cnt_t        c1,
    output dsp_pkg::cnt_t        c2,
    output logic                 con_result
);
    import dsp_pkg::*;

    logic lmi, leq, llv, lmv;
    logic cond_now;

    assign {lmi, leq, llv, lmv} = flags;

    always_comb begin
        case (ctrl.c_field)
            5'd0:       cond_now = lmi;
            5'd1:       cond_now = ~lmi;
            5'd2:       cond_now = leq;
            5'd3:       cond_now = ~leq;
            5'd4:       cond_now = llv;
            5'd5:       cond_now = ~llv;
            5'd6:       cond_now = lmv;
            5'd7:       cond_now = ~lmv;
            COND_C0GE:  cond_now = ~c0[CNT_W-1];
            COND_C0LT:  cond_now = c0[CNT_W-1];
            COND_C1GE:  cond_now = ~c1[CNT_W-1];
            COND_C1LT:  cond_now = c1[CNT_W-1];
            COND_TRUE:  cond_now = 1'b1;
            COND_FALSE: cond_now = 1'b0;
            COND_GT:    cond_now = ~lmi & ~leq;
            COND_LE:    cond_now = lmi | leq;
            default:    cond_now = 1'b1;   // unassigned codes read as true
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            c0         <= '0;
            c1         <= '0;
            c2         <= '0;
            con_result <= 1'b0;
        end else begin
            if (ctrl.ld_en) begin
                case (ctrl.ld_sel)
                    R_C0:    c0 <= ctrl.ld_data[CNT_W-1:0];
                    R_C1:    c1 <= ctrl.ld_data[CNT_W-1:0];
                    R_C2:    c2 <= ctrl.ld_data[CNT_W-1:0];
                    default: ;
                endcase
            end
            if (ctrl.cond_en) begin
                con_result <= cond_now;  // uses counters before the step
                if (ctrl.c_field inside {COND_C0GE, COND_C0LT}) c0 <= c0 + 1'b1;
                if (ctrl.c_field inside {COND_C1GE, COND_C1LT}) c1 <= c1 + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dau_datapath.sv
// ======================================================================
// datapath of the arithmetic unit
// x, yh, yl and product registers, accumulators a0 and a1
// auc, flags, overflow latches and the psw view
// register read multiplexer including the counters
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module dau_datapath (
    input  wire                  clk,
    input  wire                  rst,
    dau_ctrl_if.dp               ctrl,
    input  wire dsp_pkg::cnt_t   c0,
    input  wire dsp_pkg::cnt_t   c1,
    input  wire dsp_pkg::cnt_t   c2,
    output dsp_pkg::flags_t      flags,
    output dsp_pkg::word_t       reg_rdata
);
    import dsp_pkg::*;

    word_t            x, yh, yl;
    prod_t            p;
    prod_t            y;
    acc_t             a0, a1;
    acc_t             a_src;
    logic [AUC_W-1:0] auc;
    logic             ov0, ov1;
    word_t            psw;

    logic             d_bit, s_bit;
    logic [3:0]       f1;
    logic             f1_def;
    logic             p_upd, flag_upd, acc_st;

    alu_t             result;
    flags_t           flags_next;
    logic             ovf;

    assign {d_bit, s_bit, f1} = ctrl.op_word;

    assign f1_def = f1 inside {F1_P, F1_ADDP, F1_MPY, F1_SUBP, F1_OR, F1_XOR,
                               F1_TST, F1_Y, F1_ADDY, F1_SUBY};

    assign p_upd    = ctrl.op_en && f1[3:2] == 2'b00;   // codes 0..3
    assign flag_upd = ctrl.op_en && f1_def && f1 != F1_MPY;
    assign acc_st   = flag_upd && f1 != F1_TST;

    assign y     = {yh, yl};
    assign a_src = s_bit ? a1 : a0;

    dau_alu u_alu (
        .op_word    (ctrl.op_word),
        .a_src      (a_src),
        .p          (p),           // value before this edge
        .y          (y),
        .auc_scale  (auc[1:0]),
        .result     (result),
        .flags_next (flags_next),
        .ovf        (ovf)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x     <= '0;
            yh    <= '0;
            yl    <= '0;
            p     <= '0;
            a0    <= '0;
            a1    <= '0;
            auc   <= '0;
            flags <= '0;
            ov0   <= 1'b0;
            ov1   <= 1'b0;
        end else begin
            if (ctrl.ld_en) begin
                case (ctrl.ld_sel)
                    R_X:   x <= ctrl.ld_data;
                    R_YH: begin
                        yh <= ctrl.ld_data;
                        if (!auc[6]) yl <= '0;  // yl clear unless auc[6]
                    end
                    R_YL:  yl <= ctrl.ld_data;
                    R_AUC: auc <= ctrl.ld_data[AUC_W-1:0];
                    default: ;                  // psw read only and counters in dau_cond
                endcase
            end
            if (p_upd) p <= $signed(x) * $signed(yh);
            if (acc_st) begin
                if (d_bit) a1 <= result[ACC_W-1:0];
                else       a0 <= result[ACC_W-1:0];
            end
            if (flag_upd) begin
                flags <= flags_next;
                ov1   <= d_bit & ovf;
                ov0   <= ~d_bit & ovf;
            end
        end
    end

    assign psw = {flags, 2'b00, ov1, ov0, a1[ACC_W-1:PROD_W], a0[ACC_W-1:PROD_W]};

    always_comb begin
        case (ctrl.rd_sel)
            {1'b0, R_X}:   reg_rdata = x;
            {1'b0, R_YH}:  reg_rdata = yh;
            {1'b0, R_YL}:  reg_rdata = yl;
            {1'b0, R_AUC}: reg_rdata = {{(WORD_W-AUC_W){1'b0}}, auc};
            {1'b0, R_PSW}: reg_rdata = psw;
            {1'b0, R_C0}:  reg_rdata = {{(WORD_W-CNT_W){c0[CNT_W-1]}}, c0};
            {1'b0, R_C1}:  reg_rdata = {{(WORD_W-CNT_W){c1[CNT_W-1]}}, c1};
            {1'b0, R_C2}:  reg_rdata = {{(WORD_W-CNT_W){c2[CNT_W-1]}}, c2};
            RD_A0H:        reg_rdata = a0[PROD_W-1:WORD_W];
            RD_A0L:        reg_rdata = a0[WORD_W-1:0];
            RD_A1H:        reg_rdata = a1[PROD_W-1:WORD_W];
            RD_A1L:        reg_rdata = a1[WORD_W-1:0];
            default:       reg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/dau_alu.sv
// ======================================================================
// F1 ALU of the arithmetic unit, purely combinational
// product scaling by auc, 37-bit add, subtract and logic ops
// next values of the lmi, leq, llv and lmv flags
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module dau_alu (
    input  wire dsp_pkg::op_word_t  op_word,
    input  wire dsp_pkg::acc_t      a_src,
    input  wire dsp_pkg::prod_t     p,
    input  wire dsp_pkg::prod_t     y,
    input  wire [1:0]               auc_scale,
    output dsp_pkg::alu_t           result,
    output dsp_pkg::flags_t         flags_next,
    output logic                    ovf
);
    import dsp_pkg::*;

    logic [3:0] f1;
    alu_t       as_ext;   // source accumulator, one sign bit on top
    alu_t       p_ext;
    alu_t       y_ext;
    logic       lmi, leq, llv, lmv;

    assign f1     = op_word[3:0];
    assign as_ext = {a_src[ACC_W-1], a_src};
    assign y_ext  = {{(ALU_W-PROD_W){y[PROD_W-1]}}, y};

    always_comb begin
        case (auc_scale)
            2'd1, 2'd3: p_ext = {{(ALU_W-PROD_W+2){p[PROD_W-1]}}, p[PROD_W-1:2]};  // >> 2
            2'd2:       p_ext = {{(ALU_W-PROD_W-2){p[PROD_W-1]}}, p, 2'b00};      // << 2
            default:    p_ext = {{(ALU_W-PROD_W){p[PROD_W-1]}}, p};
        endcase
    end

    always_comb begin
        case (f1)
            F1_P:    result = p_ext;
            F1_ADDP: result = as_ext + p_ext;
            F1_SUBP: result = as_ext - p_ext;
            F1_OR:   result = as_ext | y_ext;
            F1_XOR:  result = as_ext ^ y_ext;
            F1_TST:  result = as_ext & y_ext;  // flags only
            F1_Y:    result = y_ext;
            F1_ADDY: result = as_ext + y_ext;
            F1_SUBY: result = as_ext - y_ext;
            default: result = as_ext;           // F1_MPY and reserved pass the source
        endcase
    end

    assign lmi = result[ACC_W-1];
    assign leq = ~|result[ACC_W-1:0];
    assign llv = result[ALU_W-1] ^ result[ACC_W-1];
    // guard bits plus bit 31 not all equal
    assign lmv = !(&result[ACC_W-1:PROD_W-1] || ~|result[ACC_W-1:PROD_W-1]);

    assign flags_next = {lmi, leq, llv, lmv};
    assign ovf        = llv;

endmodule

`default_nettype wire

//--- source/apb_dau_port.sv
// ======================================================================
// APB slave port of the arithmetic unit, zero wait states
// decodes access phases into load, operation and condition strobes
// raises pslverr on unmapped or illegal accesses
// maps read addresses to the read select and returns read data
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module apb_dau_port (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         psel,
    input  wire                         penable,
    input  wire                         pwrite,
    input  wire [dsp_pkg::APB_AW-1:0]   paddr,
    input  wire [dsp_pkg::APB_DW-1:0]   pwdata,
    output logic [dsp_pkg::APB_DW-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr,
    dau_ctrl_if.host                    ctrl,
    input  wire dsp_pkg::word_t         reg_rdata,
    input  wire                         con_result
);
    import dsp_pkg::*;

    logic    setup_q;     // previous cycle was a setup phase
    logic    access, wr, rd;
    logic    reg_hit, acc_hit, op_hit, cond_hit;
    logic    err;
    r_code_t code;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= psel && !penable;
        end
    end

    assign access = psel && penable && setup_q;
    assign wr     = access && pwrite;
    assign rd     = access && !pwrite;

    assign code     = paddr[4:2];  // word index in the register area
    assign reg_hit  = {paddr[APB_AW-1:5], 3'b000, paddr[1:0]} == ADDR_REG_BASE;
    assign acc_hit  = paddr inside {ADDR_A0H, ADDR_A0L, ADDR_A1H, ADDR_A1L};
    assign op_hit   = paddr == ADDR_OP;
    assign cond_hit = paddr == ADDR_COND;

    always_comb begin
        err = 1'b0;
        if (!(reg_hit || acc_hit || op_hit || cond_hit)) begin
            err = 1'b1;
        end else if (pwrite && ((reg_hit && code == R_PSW) || acc_hit)) begin
            err = 1'b1;  // psw and accumulators are read only here
        end else if (!pwrite && op_hit) begin
            err = 1'b1;
        end
    end

    assign pready  = 1'b1;
    assign pslverr = access && err;

    // exactly one strobe per good write
    assign ctrl.ld_en   = wr && reg_hit && !err;
    assign ctrl.op_en   = wr && op_hit;
    assign ctrl.cond_en = wr && cond_hit;

    assign ctrl.ld_sel  = code;
    assign ctrl.ld_data = pwdata[WORD_W-1:0];
    assign ctrl.op_word = pwdata[5:0];
    assign ctrl.c_field = pwdata[4:0];

    always_comb begin
        case (paddr)
            ADDR_A0H: ctrl.rd_sel = RD_A0H;
            ADDR_A0L: ctrl.rd_sel = RD_A0L;
            ADDR_A1H: ctrl.rd_sel = RD_A1H;
            ADDR_A1L: ctrl.rd_sel = RD_A1L;
            default:  ctrl.rd_sel = {1'b0, code};
        endcase
    end

    always_comb begin
        prdata = '0;
        if (rd && !err) begin
            if (cond_hit) begin
                prdata = {{(APB_DW-1){1'b0}}, con_result};
            end else begin
                prdata = {{(APB_DW-WORD_W){1'b0}}, reg_rdata};
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dau_ctrl_if.sv
// ======================================================================
// command interface from the APB port to the arithmetic unit
// register load, F1 operation, condition and read-select fields
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

interface dau_ctrl_if;
    import dsp_pkg::*;

    logic     ld_en;     // single-cycle strobes
    r_code_t  ld_sel;
    word_t    ld_data;
    logic     op_en;
    op_word_t op_word;
    logic     cond_en;
    cond_t    c_field;
    rd_sel_t  rd_sel;

    modport host (
        output ld_en, ld_sel, ld_data, op_en, op_word, cond_en, c_field, rd_sel
    );

    modport dp (input ld_en, ld_sel, ld_data, op_en, op_word, rd_sel);

    modport cu (input ld_en, ld_sel, ld_data, cond_en, c_field);

endinterface

`default_nettype wire

//--- source/dsp_pkg.sv
// ======================================================================
// shared definitions of the DSP data arithmetic unit
// widths and data types of words, products, accumulators and counters
// F1 operation codes, register and read-select codes, condition codes
// APB address map of the slave port
// ======================================================================
`default_nettype none

package dsp_pkg;

    localparam int WORD_W = 16;
    localparam int PROD_W = 32;
    localparam int ACC_W  = 36;          // 4 guard bits over 32 data bits
    localparam int ALU_W  = ACC_W + 1;   // extra bit for overflow test
    localparam int CNT_W  = 8;
    localparam int AUC_W  = 7;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [PROD_W-1:0] prod_t;
    typedef logic [ACC_W-1:0]  acc_t;
    typedef logic [ALU_W-1:0]  alu_t;
    typedef logic [CNT_W-1:0]  cnt_t;
    typedef logic [3:0]        flags_t;    // lmi, leq, llv, lmv
    typedef logic [2:0]        r_code_t;
    typedef logic [3:0]        rd_sel_t;
    typedef logic [5:0]        op_word_t;  // d, s, f1
    typedef logic [4:0]        cond_t;

    // register codes
    localparam r_code_t R_X   = 3'd0;
    localparam r_code_t R_YH  = 3'd1;
    localparam r_code_t R_YL  = 3'd2;
    localparam r_code_t R_AUC = 3'd3;
    localparam r_code_t R_PSW = 3'd4;
    localparam r_code_t R_C0  = 3'd5;
    localparam r_code_t R_C1  = 3'd6;
    localparam r_code_t R_C2  = 3'd7;

    // accumulator halves on the read mux
    localparam rd_sel_t RD_A0H = 4'd8;
    localparam rd_sel_t RD_A0L = 4'd9;
    localparam rd_sel_t RD_A1H = 4'd10;
    localparam rd_sel_t RD_A1L = 4'd11;

    // F1 codes, the rest are reserved
    localparam logic [3:0] F1_P    = 4'd0;
    localparam logic [3:0] F1_ADDP = 4'd1;
    localparam logic [3:0] F1_MPY  = 4'd2;
    localparam logic [3:0] F1_SUBP = 4'd3;
    localparam logic [3:0] F1_OR   = 4'd8;
    localparam logic [3:0] F1_XOR  = 4'd9;
    localparam logic [3:0] F1_TST  = 4'd10;
    localparam logic [3:0] F1_Y    = 4'd12;
    localparam logic [3:0] F1_ADDY = 4'd13;
    localparam logic [3:0] F1_SUBY = 4'd15;

    // counter and compound conditions
    localparam cond_t COND_C0GE  = 5'd10;
    localparam cond_t COND_C0LT  = 5'd11;
    localparam cond_t COND_C1GE  = 5'd12;
    localparam cond_t COND_C1LT  = 5'd13;
    localparam cond_t COND_TRUE  = 5'd14;
    localparam cond_t COND_FALSE = 5'd15;
    localparam cond_t COND_GT    = 5'd16;
    localparam cond_t COND_LE    = 5'd17;

    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    localparam logic [APB_AW-1:0] ADDR_REG_BASE = 8'h00;  // 8 words by register code
    localparam logic [APB_AW-1:0] ADDR_OP       = 8'h20;
    localparam logic [APB_AW-1:0] ADDR_COND     = 8'h24;
    localparam logic [APB_AW-1:0] ADDR_A0H      = 8'h28;
    localparam logic [APB_AW-1:0] ADDR_A0L      = 8'h2C;
    localparam logic [APB_AW-1:0] ADDR_A1H      = 8'h30;
    localparam logic [APB_AW-1:0] ADDR_A1L      = 8'h34;

endpackage

`default_nettype wire
